// File: Makefile
SIM := obj_dir/Vtb_arith_axil_top

.PHONY: run clean

run: $(SIM)
	out=$$($(SIM)); echo "$$out"; echo "$$out" | grep -q -F '*** PASSED ***'

$(SIM): build.f $(wildcard *.sv)
	verilator --binary --timing -j 0 --top-module tb_arith_axil_top -f build.f

clean:
	rm -rf obj_dir

// File: arith_axil_top.sv
// coprocessor top level; the bus side supports one outstanding read and one outstanding write.
module arith_axil_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  arith_pkg::axil_req_t axil_req_i,
    output arith_pkg::axil_rsp_t axil_rsp_o
);
    import arith_pkg::*;

    reg_t                      wr_regs;
    reg_t                      rd_regs;
    reg_mask_t                 wr_valid;
    reg_mask_t                 rd_valid;
    reg_mask_t                 rd_request;
    logic                      cmd_req;
    logic                      cmd_ack;
    arith_cmd_t                cmd;
    logic [REG_DATA_WIDTH-1:0] result;

    axil_reg_file u_reg_file (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .rd_regs_i   (rd_regs),
        .rd_valid_i  (rd_valid),
        .rd_request_o(rd_request),
        .wr_regs_o   (wr_regs),
        .wr_valid_o  (wr_valid)
    );

    cmd_bridge u_bridge (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .wr_regs_i   (wr_regs),
        .wr_valid_i  (wr_valid),
        .rd_request_i(rd_request),
        .rd_regs_o   (rd_regs),
        .rd_valid_o  (rd_valid),
        .cmd_req_o   (cmd_req),
        .cmd_o       (cmd),
        .cmd_ack_i   (cmd_ack),
        .result_i    (result)
    );

    arith_engine u_engine (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .cmd_req_i(cmd_req),
        .cmd_i    (cmd),
        .cmd_ack_o(cmd_ack),
        .result_o (result)
    );

endmodule

// File: arith_engine.sv
// expects a four-phase req/ack; multiply keeps only the low 32 bits of the product.
module arith_engine (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  cmd_req_i,
    input  arith_pkg::arith_cmd_t cmd_i,
    output logic                  cmd_ack_o,
    output logic [31:0]           result_o
);
    import arith_pkg::*;

    typedef enum logic [1:0] {IDLE, RUN, ACK} state_e;

    state_e                    state_q;
    logic                      ack_q;
    logic [4:0]                step_q;
    arith_cmd_t                cmd_q;
    logic [REG_DATA_WIDTH-1:0] acc_q;
    logic [REG_DATA_WIDTH-1:0] mul_sum;
    logic [REG_DATA_WIDTH-1:0] alu_res;

    // one shift-add step. a moves left and b moves right each cycle.
    assign mul_sum = acc_q + (cmd_q.b[0] ? cmd_q.a : '0);

    always_comb begin
        case (cmd_q.op)
            OP_ADD:  alu_res = cmd_q.a + cmd_q.b;
            OP_SUB:  alu_res = cmd_q.a - cmd_q.b;
            OP_MUL:  alu_res = mul_sum;
            OP_AND:  alu_res = cmd_q.a & cmd_q.b;
            OP_XOR:  alu_res = cmd_q.a ^ cmd_q.b;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
            ack_q   <= 1'b0;
            step_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (cmd_req_i) begin
                        step_q  <= '0;
                        state_q <= RUN;
                    end
                end
                RUN: begin
                    if (cmd_q.op != OP_MUL || step_q == 5'd31) begin
                        ack_q   <= 1'b1;
                        state_q <= ACK;
                    end else begin
                        step_q <= step_q + 5'd1;
                    end
                end
                ACK: begin
                    if (!cmd_req_i) begin
                        ack_q   <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && cmd_req_i) begin
            cmd_q <= cmd_i;
            acc_q <= '0;
        end
        if (state_q == RUN) begin
            acc_q <= alu_res;
            if (cmd_q.op == OP_MUL) begin
                cmd_q.a <= cmd_q.a << 1;
                cmd_q.b <= cmd_q.b >> 1;
            end
        end
    end

    assign cmd_ack_o = ack_q;
    assign result_o  = acc_q; // holds through ACK since acc only moves in RUN.

endmodule

// File: arith_pkg.sv
// shared definitions for the coprocessor; only five registers are mapped and unknown opcodes give zero.
package arith_pkg;

    localparam int REG_DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 8;
    localparam int REG_NUM        = 5;

    // word address bits that select one of the registers.
    localparam int ADDR_LSB = 2;
    localparam int ADDR_MSB = 4;

    localparam int REG_CTRL   = 0;
    localparam int REG_OPA    = 1;
    localparam int REG_OPB    = 2;
    localparam int REG_RESULT = 3;
    localparam int REG_STATUS = 4;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef logic [REG_NUM-1:0][REG_DATA_WIDTH-1:0] reg_t;
    typedef logic [REG_NUM-1:0] reg_mask_t;

    localparam reg_t REG_INIT = '0;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_MUL = 3'd2,
        OP_AND = 3'd3,
        OP_XOR = 3'd4
    } arith_op_e;

    typedef struct packed {
        arith_op_e                 op;
        logic [REG_DATA_WIDTH-1:0] a;
        logic [REG_DATA_WIDTH-1:0] b;
    } arith_cmd_t;

    // layout of the STATUS word as software sees it.
    typedef struct packed {
        logic [15:0] reserved_hi;
        logic [7:0]  count;
        logic [4:0]  reserved_lo;
        logic        overrun;
        logic        done;
        logic        busy;
    } status_t;

    typedef struct packed {
        logic                        aw_valid;
        logic [REG_ADDR_WIDTH-1:0]   aw_addr;
        logic                        w_valid;
        logic [REG_DATA_WIDTH-1:0]   w_data;
        logic [REG_DATA_WIDTH/8-1:0] w_strb;
        logic                        b_ready;
        logic                        ar_valid;
        logic [REG_ADDR_WIDTH-1:0]   ar_addr;
        logic                        r_ready;
    } axil_req_t;

    typedef struct packed {
        logic                      aw_ready;
        logic                      w_ready;
        logic                      b_valid;
        logic [1:0]                b_resp;
        logic                      ar_ready;
        logic                      r_valid;
        logic [REG_DATA_WIDTH-1:0] r_data;
        logic [1:0]                r_resp;
    } axil_rsp_t;

endpackage

// File: axil_reg_file.sv
// AXI4-Lite slave with one read and one write in flight; responses are always OKAY.
module axil_reg_file (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  arith_pkg::axil_req_t axil_req_i,
    output arith_pkg::axil_rsp_t axil_rsp_o,
    input  arith_pkg::reg_t      rd_regs_i,
    input  arith_pkg::reg_mask_t rd_valid_i,
    output arith_pkg::reg_mask_t rd_request_o,
    output arith_pkg::reg_t      wr_regs_o,
    output arith_pkg::reg_mask_t wr_valid_o
);
    import arith_pkg::*;

    logic                       wr_ready_q;
    logic                       b_valid_q;
    logic                       ar_ready_q;
    logic                       r_valid_q;
    logic [REG_DATA_WIDTH-1:0]  r_data_q;
    logic [REG_DATA_WIDTH-1:0]  rd_word;
    logic [ADDR_MSB-ADDR_LSB:0] wr_sel;
    logic [ADDR_MSB-ADDR_LSB:0] rd_sel;
    logic                       wr_en;
    logic                       rd_en;
    reg_t                       wr_regs_q;
    reg_t                       rd_regs_q;
    reg_mask_t                  wr_valid_q;
    reg_mask_t                  rd_request_q;

    // the master holds address and data until the handshake, so no copy is kept.
    assign wr_sel = axil_req_i.aw_addr[ADDR_MSB:ADDR_LSB];
    assign rd_sel = axil_req_i.ar_addr[ADDR_MSB:ADDR_LSB];

    assign wr_en = axil_req_i.aw_valid & axil_req_i.w_valid & wr_ready_q;
    assign rd_en = axil_req_i.ar_valid & ar_ready_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ready_q <= 1'b0;
        end else begin
            wr_ready_q <= axil_req_i.aw_valid & axil_req_i.w_valid & ~wr_ready_q & ~b_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            b_valid_q <= 1'b0;
        end else if (wr_en) begin
            b_valid_q <= 1'b1;
        end else if (axil_req_i.b_ready) begin
            b_valid_q <= 1'b0;
        end
    end

    // byte lanes without a strobe keep their old value.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_regs_q  <= REG_INIT;
            wr_valid_q <= '0;
        end else begin
            wr_valid_q <= '0;
            if (wr_en) begin
                for (int r = 0; r < REG_NUM; r++) begin
                    if (int'(wr_sel) == r) begin
                        for (int i = 0; i < REG_DATA_WIDTH / 8; i++) begin
                            if (axil_req_i.w_strb[i]) begin
                                wr_regs_q[r][i*8+:8] <= axil_req_i.w_data[i*8+:8];
                            end
                        end
                        wr_valid_q[r] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ar_ready_q <= 1'b0;
        end else begin
            ar_ready_q <= axil_req_i.ar_valid & ~ar_ready_q & ~r_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            r_valid_q <= 1'b0;
        end else if (rd_en) begin
            r_valid_q <= 1'b1;
        end else if (axil_req_i.r_ready) begin
            r_valid_q <= 1'b0;
        end
    end

    always_comb begin
        rd_word = '0; // unmapped addresses read as zero.
        for (int r = 0; r < REG_NUM; r++) begin
            if (int'(rd_sel) == r) begin
                rd_word = rd_regs_q[r];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            r_data_q <= rd_word;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rd_regs_q <= REG_INIT;
        end else begin
            for (int r = 0; r < REG_NUM; r++) begin
                if (rd_valid_i[r]) begin
                    rd_regs_q[r] <= rd_regs_i[r];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rd_request_q <= '0;
        end else begin
            rd_request_q <= '0;
            for (int r = 0; r < REG_NUM; r++) begin
                if (rd_en && int'(rd_sel) == r) begin
                    rd_request_q[r] <= 1'b1; // same cycle as r_valid rising.
                end
            end
        end
    end

    always_comb begin
        axil_rsp_o          = '0;
        axil_rsp_o.aw_ready = wr_ready_q;
        axil_rsp_o.w_ready  = wr_ready_q;
        axil_rsp_o.b_valid  = b_valid_q;
        axil_rsp_o.b_resp   = AXI_RESP_OKAY;
        axil_rsp_o.ar_ready = ar_ready_q;
        axil_rsp_o.r_valid  = r_valid_q;
        axil_rsp_o.r_data   = r_data_q;
        axil_rsp_o.r_resp   = AXI_RESP_OKAY;
    end

    assign wr_regs_o    = wr_regs_q;
    assign wr_valid_o   = wr_valid_q;
    assign rd_request_o = rd_request_q;

endmodule

// File: build.f
arith_pkg.sv
axil_reg_file.sv
cmd_bridge.sv
arith_engine.sv
arith_axil_top.sv
tb_arith_axil_top.sv

// File: cmd_bridge.sv
// one command at a time; a CTRL write while busy is dropped and only flags overrun.
module cmd_bridge (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  arith_pkg::reg_t       wr_regs_i,
    input  arith_pkg::reg_mask_t  wr_valid_i,
    input  arith_pkg::reg_mask_t  rd_request_i,
    output arith_pkg::reg_t       rd_regs_o,
    output arith_pkg::reg_mask_t  rd_valid_o,
    output logic                  cmd_req_o,
    output arith_pkg::arith_cmd_t cmd_o,
    input  logic                  cmd_ack_i,
    input  logic [31:0]           result_i
);
    import arith_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} state_e;

    state_e                    state_q;
    logic                      req_q;
    logic                      done_q;
    logic [1:0]                done_seen_q;
    logic                      overrun_q;
    logic                      busy;
    logic [7:0]                count_q;
    logic [REG_DATA_WIDTH-1:0] result_q;
    arith_cmd_t                cmd_q;
    reg_mask_t                 rd_valid_q;
    status_t                   status;

    assign busy = (state_q != IDLE);

    // done and the count move when the handshake closes, so a poll never sees done with busy.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= IDLE;
            req_q     <= 1'b0;
            done_q    <= 1'b0;
            overrun_q <= 1'b0;
            count_q   <= '0;
        end else begin
            if (rd_request_i[REG_STATUS] && done_seen_q[1]) begin
                done_q <= 1'b0; // only a read that returned done clears it.
            end
            if (wr_valid_i[REG_CTRL] && busy) begin
                overrun_q <= 1'b1;
            end
            case (state_q)
                IDLE: begin
                    if (wr_valid_i[REG_CTRL]) begin
                        req_q   <= 1'b1;
                        state_q <= REQ;
                    end
                end
                REQ: begin
                    if (cmd_ack_i) begin
                        req_q   <= 1'b0;
                        state_q <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: begin
                    if (!cmd_ack_i) begin
                        done_q  <= 1'b1;
                        count_q <= count_q + 8'd1;
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // done as the bus returns it, two registers behind done_q.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            done_seen_q <= '0;
        end else begin
            done_seen_q <= {done_seen_q[0], done_q};
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && wr_valid_i[REG_CTRL]) begin
            cmd_q.op <= arith_op_e'(wr_regs_i[REG_CTRL][2:0]);
            cmd_q.a  <= wr_regs_i[REG_OPA];
            cmd_q.b  <= wr_regs_i[REG_OPB];
        end
        if (state_q == REQ && cmd_ack_i) begin
            result_q <= result_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rd_valid_q <= '0;
        end else begin
            rd_valid_q[REG_CTRL]   <= wr_valid_i[REG_CTRL];
            rd_valid_q[REG_OPA]    <= wr_valid_i[REG_OPA];
            rd_valid_q[REG_OPB]    <= wr_valid_i[REG_OPB];
            rd_valid_q[REG_RESULT] <= (state_q == REQ) && cmd_ack_i;
            rd_valid_q[REG_STATUS] <= 1'b1; // the status copy follows every cycle.
        end
    end

    always_comb begin
        status         = '0;
        status.busy    = busy;
        status.done    = done_q;
        status.overrun = overrun_q;
        status.count   = count_q;
    end

    always_comb begin
        rd_regs_o             = '0;
        rd_regs_o[REG_CTRL]   = wr_regs_i[REG_CTRL];
        rd_regs_o[REG_OPA]    = wr_regs_i[REG_OPA];
        rd_regs_o[REG_OPB]    = wr_regs_i[REG_OPB];
        rd_regs_o[REG_RESULT] = result_q;
        rd_regs_o[REG_STATUS] = status;
        rd_valid_o            = rd_valid_q;
    end

    assign cmd_req_o = req_q;
    assign cmd_o     = cmd_q;

endmodule

// File: tb_arith_axil_top.sv
// runs one AXI4-Lite transaction at a time; overrun is sticky, so the overrun case runs last.
module tb_arith_axil_top;
    import arith_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_ROWS        = 7;
    localparam int WATCHDOG_CYCLES = 200 * NUM_ROWS + 2000;

    typedef struct packed {
        logic [2:0]                op;
        logic [REG_DATA_WIDTH-1:0] a;
        logic [REG_DATA_WIDTH-1:0] b;
        logic [REG_DATA_WIDTH-1:0] expected;
    } row_t;

    logic        clk_i;
    logic        rstn_i;
    axil_req_t   req;
    axil_rsp_t   rsp;
    logic [31:0] rng_state = 32'd89150;

    // expected values are worked out by hand from the opcode rules.
    row_t rows [NUM_ROWS] = '{
        '{OP_ADD, 32'hFFFF_FFF0, 32'h0000_0020, 32'h0000_0010}, // carry falls off the top.
        '{OP_SUB, 32'h0000_0005, 32'h0000_0007, 32'hFFFF_FFFE}, // borrow wraps.
        '{OP_MUL, 32'h0001_0001, 32'h0001_0001, 32'h0002_0001},
        '{OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001},
        '{OP_AND, 32'hF0F0_1234, 32'hFF00_0F0F, 32'hF000_0204},
        '{OP_XOR, 32'hA5A5_5A5A, 32'hFFFF_0000, 32'h5A5A_5A5A},
        '{3'd7,   32'h1234_5678, 32'h1111_1111, 32'h0000_0000}  // unknown code gives zero.
    };

    arith_axil_top dut (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .axil_req_i(req),
        .axil_rsp_o(rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [REG_ADDR_WIDTH-1:0] reg_addr(input int idx);
        return REG_ADDR_WIDTH'(idx << ADDR_LSB);
    endfunction

    function automatic status_t make_status(input logic busy, input logic done,
                                            input logic overrun, input int count);
        status_t s;
        s         = '0;
        s.busy    = busy;
        s.done    = done;
        s.overrun = overrun;
        s.count   = 8'(count);
        return s;
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input logic [REG_DATA_WIDTH-1:0] got,
                              input logic [REG_DATA_WIDTH-1:0] expected, input string what);
        if (got !== expected) begin
            report_failure($sformatf("[FAIL] t=%0t %s: got 0x%08h, expected 0x%08h",
                                     $time, what, got, expected));
        end
    endtask

    task automatic check_status(input status_t got, input status_t expected, input string what);
        if (got !== expected) begin
            report_failure($sformatf(
                "[FAIL] t=%0t %s: busy=%0b done=%0b overrun=%0b count=%0d, expected %0b %0b %0b %0d",
                $time, what, got.busy, got.done, got.overrun, got.count,
                expected.busy, expected.done, expected.overrun, expected.count));
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] expected,
                              input string what);
        if (got !== expected) begin
            report_failure($sformatf("[FAIL] t=%0t %s: got resp %0d, expected %0d",
                                     $time, what, got, expected));
        end
    endtask

    // the ready lines are held back by zero to three cycles.
    task automatic wait_random_cycles();
        int n;
        n = int'(xorshift32() & 32'd3);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic axil_write(input logic [REG_ADDR_WIDTH-1:0] addr,
                              input logic [REG_DATA_WIDTH-1:0] data, input logic [3:0] strb);
        req.aw_valid = 1'b1;
        req.aw_addr  = addr;
        req.w_valid  = 1'b1;
        req.w_data   = data;
        req.w_strb   = strb;
        @(negedge clk_i);
        while (!rsp.aw_ready && !rsp.w_ready) @(negedge clk_i);
        if (rsp.aw_ready !== rsp.w_ready) begin
            report_failure($sformatf("[FAIL] t=%0t aw_ready=%0b and w_ready=%0b differ",
                                     $time, rsp.aw_ready, rsp.w_ready));
        end
        @(posedge clk_i);
        #1;
        req.aw_valid = 1'b0;
        req.w_valid  = 1'b0;
        wait_random_cycles();
        req.b_ready = 1'b1;
        @(negedge clk_i);
        while (!rsp.b_valid) @(negedge clk_i);
        check_resp(rsp.b_resp, AXI_RESP_OKAY, "write response");
        @(posedge clk_i);
        #1;
        req.b_ready = 1'b0;
    endtask

    task automatic axil_read(input logic [REG_ADDR_WIDTH-1:0] addr,
                             output logic [REG_DATA_WIDTH-1:0] data);
        req.ar_valid = 1'b1;
        req.ar_addr  = addr;
        @(negedge clk_i);
        while (!rsp.ar_ready) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        req.ar_valid = 1'b0;
        wait_random_cycles();
        req.r_ready = 1'b1;
        @(negedge clk_i);
        while (!rsp.r_valid) @(negedge clk_i);
        data = rsp.r_data; // sampled mid-cycle while r_valid is stable.
        check_resp(rsp.r_resp, AXI_RESP_OKAY, "read response");
        @(posedge clk_i);
        #1;
        req.r_ready = 1'b0;
    endtask

    task automatic poll_until_done(output status_t status);
        logic [REG_DATA_WIDTH-1:0] data;
        do begin
            axil_read(reg_addr(REG_STATUS), data);
            status = status_t'(data);
        end while (!status.done);
    endtask

    task automatic run_row(input row_t row, input int count);
        logic [REG_DATA_WIDTH-1:0] data;
        status_t                   status;
        axil_write(reg_addr(REG_OPA), row.a, 4'hF);
        axil_write(reg_addr(REG_OPB), row.b, 4'hF);
        axil_write(reg_addr(REG_CTRL), 32'(row.op), 4'hF);
        poll_until_done(status);
        check_status(status, make_status(1'b0, 1'b1, 1'b0, count), "first status after done");
        axil_read(reg_addr(REG_STATUS), data);
        check_status(status_t'(data), make_status(1'b0, 1'b0, 1'b0, count), "second status read");
        axil_read(reg_addr(REG_RESULT), data);
        check_word(data, row.expected, $sformatf("result of row %0d", count));
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure($sformatf("timeout: the run did not finish within %0d clock cycles",
                                 WATCHDOG_CYCLES));
    end

    initial begin
        logic [REG_DATA_WIDTH-1:0] data;
        status_t                   status;
        req    = '0;
        rstn_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        for (int r = 0; r < REG_NUM; r++) begin
            axil_read(reg_addr(r), data);
            check_word(data, '0, $sformatf("register %0d after reset", r));
        end

        axil_write(reg_addr(REG_OPA), 32'h1122_3344, 4'hF);
        axil_read(reg_addr(REG_OPA), data);
        check_word(data, 32'h1122_3344, "OPA full write");
        axil_write(reg_addr(REG_OPB), 32'h5566_7788, 4'hF);
        axil_read(reg_addr(REG_OPB), data);
        check_word(data, 32'h5566_7788, "OPB full write");
        axil_write(reg_addr(REG_OPA), 32'hFFFF_FFFF, 4'b0101); // bytes 1 and 3 stay.
        axil_read(reg_addr(REG_OPA), data);
        check_word(data, 32'h11FF_33FF, "OPA partial write");
        axil_write(reg_addr(REG_RESULT), 32'hCAFE_F00D, 4'hF);
        axil_read(reg_addr(REG_RESULT), data);
        check_word(data, '0, "RESULT after bus write");
        axil_write(reg_addr(REG_STATUS), 32'hFFFF_FFFF, 4'hF);
        axil_read(reg_addr(REG_STATUS), data);
        check_word(data, '0, "STATUS after bus write");

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i], i + 1);
        end

        // a second CTRL write lands while the multiply is still running.
        axil_write(reg_addr(REG_OPA), 32'h0000_1000, 4'hF);
        axil_write(reg_addr(REG_OPB), 32'h0003_0000, 4'hF);
        axil_write(reg_addr(REG_CTRL), 32'(OP_MUL), 4'hF);
        axil_write(reg_addr(REG_CTRL), 32'(OP_ADD), 4'hF);
        poll_until_done(status);
        check_status(status, make_status(1'b0, 1'b1, 1'b1, NUM_ROWS + 1), "status after overrun");
        axil_read(reg_addr(REG_RESULT), data);
        check_word(data, 32'h3000_0000, "product kept after overrun");
        axil_read(reg_addr(REG_STATUS), data);
        check_status(status_t'(data), make_status(1'b0, 1'b0, 1'b1, NUM_ROWS + 1),
                     "dropped command never ran");

        $display("*** PASSED ***");
        $finish;
    end

endmodule
